// ==== Bender.yml ====
package:
  name: pov_spi

dependencies: {}

sources:
  # design, package first
  - common/pov_pkg.sv
  - spi_iff/spi_iff.sv
  - design/rotation_timer.sv
  - spi_decoder/spi_decoder.sv
  - design/pov_spi_top.sv

  # testbench
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/pov_spi_asserts.sv
      - sim/pov_spi_tb.sv

// ==== common/pov_pkg.sv ====
// shared widths, opcodes and frame layout for the pov display spi control path
package pov_pkg;

    // frame geometry, byte 0 arrives first and sits in the top bits
    localparam int FRAME_BYTES = 7;
    localparam int BYTE_W      = 8;
    localparam int FRAME_W     = FRAME_BYTES * BYTE_W;

    // byte count of a frame, 0..7
    localparam int LEN_W       = 3;

    // led driver configuration carried by a write frame
    localparam int CONF_W      = 48;

    // revolution period word and its prescaler
    localparam int ROT_W       = 16;
    localparam int ROT_DIV     = 4;
    localparam int ROT_DIV_W   = $clog2(ROT_DIV);

    // reply bit counter must hold the value ROT_W itself
    localparam int TXCNT_W     = $clog2(ROT_W + 1);

    // exact length of a set rgb enable frame
    localparam int RGB_LEN     = 2;

    // host opcodes in byte 0
    localparam logic [BYTE_W-1:0] OP_READ_ROT   = 8'h01;
    localparam logic [BYTE_W-1:0] OP_WRITE_CONF = 8'h02;
    localparam logic [BYTE_W-1:0] OP_RGB_EN     = 8'h03;

    // opcode plus payload view of a frame
    typedef struct packed {
        logic [BYTE_W-1:0] opcode;
        logic [CONF_W-1:0] payload;
    } spi_frame_s;

    // the same 56 bits seen as bytes or as command fields
    // bytes[0] is the most significant byte thanks to the ascending range
    typedef union packed {
        logic [0:FRAME_BYTES-1][BYTE_W-1:0] bytes;
        spi_frame_s                         fields;
    } spi_frame_u;

endpackage

// ==== design/pov_spi_top.sv ====
// pov spi control path top: spi slave, rotation timer and command decoder
`timescale 1ns/1ps

module pov_spi_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       hall,
    input  logic                       som_clk,
    input  logic                       som_cs,
    input  logic                       som_mosi,
    output logic                       som_miso,
    output logic [pov_pkg::ROT_W-1:0]  rotation_data,
    output logic [pov_pkg::CONF_W-1:0] configuration,
    output logic                       new_config_available,
    output logic                       rgb_enable
);
    import pov_pkg::*;

    // spi slave to decoder
    logic [FRAME_W-1:0] frame_data;
    logic [LEN_W-1:0]   frame_len;
    logic               frame_valid;

    // host link, rotation word goes back as the reply
    spi_iff i_spi_iff (
        .clk         (clk),
        .rst_n       (rst_n),
        .spi_clk     (som_clk),
        .spi_ss      (som_cs),
        .spi_mosi    (som_mosi),
        .spi_miso    (som_miso),
        .tx_data     (rotation_data),
        .frame_data  (frame_data),
        .frame_len   (frame_len),
        .frame_valid (frame_valid)
    );

    rotation_timer i_rotation_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .hall          (hall),
        .rotation_data (rotation_data)
    );

    spi_decoder i_spi_decoder (
        .clk                  (clk),
        .rst_n                (rst_n),
        .frame_data           (frame_data),
        .frame_len            (frame_len),
        .frame_valid          (frame_valid),
        .configuration        (configuration),
        .new_config_available (new_config_available),
        .rgb_enable           (rgb_enable)
    );

endmodule

// ==== design/rotation_timer.sv ====
// rotation timer: measures the revolution period between hall sensor rising edges
`timescale 1ns/1ps

module rotation_timer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      hall,
    output logic [pov_pkg::ROT_W-1:0] rotation_data
);
    import pov_pkg::*;

    // two sync stages plus history
    logic [2:0]           hall_q;
    logic                 hall_rise;
    logic [ROT_DIV_W-1:0] presc;
    logic                 presc_wrap;
    logic [ROT_W-1:0]     period_cnt;
    logic [ROT_W-1:0]     period_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hall_q <= '0;
        end else begin
            hall_q <= {hall_q[1:0], hall};
        end
    end

    assign hall_rise = hall_q[1] & ~hall_q[2];

    // prescaler reaching its last step adds one period count
    assign presc_wrap = (presc == ROT_DIV_W'(ROT_DIV - 1));

    // saturate at all ones on very slow rotation
    always_comb begin
        period_next = period_cnt;
        if (presc_wrap && period_cnt != '1) begin
            period_next = period_cnt + 1'b1;
        end
    end

    // prescaler and period counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc      <= '0;
            period_cnt <= '0;
        end else if (hall_rise) begin
            // counting restarts from zero at the edge
            presc      <= '0;
            period_cnt <= '0;
        end else begin
            presc      <= presc_wrap ? '0 : presc + 1'b1;
            period_cnt <= period_next;
        end
    end

    // latch including the step of the edge cycle, gives floor(N / ROT_DIV)
    // lands 3 clk after the hall pin rises
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rotation_data <= '0;
        end else if (hall_rise) begin
            rotation_data <= period_next;
        end
    end

endmodule

// ==== flist.f ====
common/pov_pkg.sv
spi_iff/spi_iff.sv
design/rotation_timer.sv
spi_decoder/spi_decoder.sv
design/pov_spi_top.sv
sim/tb_clk_gen.sv
sim/pov_spi_asserts.sv
sim/pov_spi_tb.sv

// ==== sim/pov_spi_asserts.sv ====
// protocol checks bound into the pov spi top: strobe width, idle miso, rgb enable timing
`timescale 1ns/1ps

module pov_spi_asserts (
    input logic clk,
    input logic rst_n,
    input logic som_cs,
    input logic som_miso,
    input logic frame_valid,
    input logic new_config_available,
    input logic rgb_enable
);

    // configuration strobe is a single cycle
    a_config_pulse_width : assert property (
        @(posedge clk) disable iff (!rst_n)
        new_config_available |=> !new_config_available
    ) else $error("new_config_available stayed high for more than one cycle");

    // slave keeps miso low while deselected
    a_miso_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        som_cs |-> !som_miso
    ) else $error("som_miso high while som_cs is high");

    // rgb enable only moves right after an end of frame strobe
    a_rgb_after_frame : assert property (
        @(posedge clk) disable iff (!rst_n)
        (rgb_enable != $past(rgb_enable)) |-> $past(frame_valid)
    ) else $error("rgb_enable changed without a preceding frame_valid");

endmodule

bind pov_spi_top pov_spi_asserts i_asserts (
    .clk                  (clk),
    .rst_n                (rst_n),
    .som_cs               (som_cs),
    .som_miso             (som_miso),
    .frame_valid          (frame_valid),
    .new_config_available (new_config_available),
    .rgb_enable           (rgb_enable)
);

// ==== sim/pov_spi_tb.sv ====
// pov spi control path testbench: spi master, hall stimulus, reference model and checks
`timescale 1ns/1ps

module pov_spi_tb;
    import pov_pkg::*;

    // sclk runs at 16 clk cycles per period
    localparam int SCLK_HALF     = 8;
    localparam int SETTLE_CYCLES = 12;
    localparam int ROT_WAIT      = 10;
    localparam int RST_WAIT      = 20;

    logic              clk;
    logic              rst_n;
    logic              hall;
    logic              som_clk;
    logic              som_cs;
    logic              som_mosi;
    logic              som_miso;
    logic [ROT_W-1:0]  rotation_data;
    logic [CONF_W-1:0] configuration;
    logic              new_config_available;
    logic              rgb_enable;

    integer            seed;
    int                errors;
    int                tests_run;
    int                tests_failed;
    int                pulse_cnt;
    int                exp_pulses;
    int                err0;
    int                i;
    logic [CONF_W-1:0] exp_conf;
    logic              exp_rgb;
    logic [71:0]       miso;
    logic [63:0]       rnd;

    tb_clk_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pov_spi_top i_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .hall                 (hall),
        .som_clk              (som_clk),
        .som_cs               (som_cs),
        .som_mosi             (som_mosi),
        .som_miso             (som_miso),
        .rotation_data        (rotation_data),
        .configuration        (configuration),
        .new_config_available (new_config_available),
        .rgb_enable           (rgb_enable)
    );

    // count strobes on the falling edge where the level is settled
    always @(negedge clk) begin
        if (rst_n && new_config_available) begin
            pulse_cnt <= pulse_cnt + 1;
        end
    end

    // expected period word, floor of cycles over prescale, clipped at all ones
    function automatic logic [ROT_W-1:0] predict_rotation(input longint n);
        longint q;
        q = n / ROT_DIV;
        if (q > 65535) begin
            q = 65535;
        end
        return ROT_W'(q);
    endfunction

    // expected decoder state after one frame, packed as {pulse, rgb, conf}
    function automatic logic [CONF_W+1:0] predict_frame(input logic [71:0] bytes, input int n,
                                                        input logic [CONF_W-1:0] conf,
                                                        input logic rgb);
        logic [CONF_W-1:0] next_conf;
        logic              next_rgb;
        logic              pulse;
        next_conf = conf;
        next_rgb  = rgb;
        pulse     = 1'b0;
        // longer frames are dropped whatever the opcode
        if (n <= FRAME_BYTES) begin
            if (bytes[71:64] == OP_WRITE_CONF && n == FRAME_BYTES) begin
                next_conf = bytes[63:16];
                pulse     = 1'b1;
            end else if (bytes[71:64] == OP_RGB_EN && n == 2) begin
                // bit 0 of byte 1
                next_rgb = bytes[56];
            end
        end
        return {pulse, next_rgb, next_conf};
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    endtask

    // mode 0 master, byte 0 in the top bits, miso captured just before each rising sclk
    task automatic spi_transfer(input logic [71:0] mosi_bytes, input int n_bytes,
                                output logic [71:0] miso_bytes);
        int b;
        int j;
        int k;
        miso_bytes = '0;
        @(negedge clk);
        som_cs = 1'b0;
        for (b = 0; b < n_bytes; b++) begin
            for (j = 0; j < 8; j++) begin
                som_mosi = mosi_bytes[71 - 8 * b - j];
                for (k = 0; k < SCLK_HALF; k++) @(negedge clk);
                miso_bytes[71 - 8 * b - j] = som_miso;
                som_clk = 1'b1;
                for (k = 0; k < SCLK_HALF; k++) @(negedge clk);
                som_clk = 1'b0;
            end
        end
        for (k = 0; k < SCLK_HALF; k++) @(negedge clk);
        som_cs   = 1'b1;
        som_mosi = 1'b0;
    endtask

    // watch for the strobe, then a quiet tail that would expose a second one
    task automatic finish_frame(input logic expect_pulse);
        int  k;
        bit  seen;
        seen = 1'b0;
        for (k = 0; k < SETTLE_CYCLES && !seen; k++) begin
            @(negedge clk);
            if (new_config_available) begin
                seen = 1'b1;
            end
        end
        if (expect_pulse && !seen) begin
            errors++;
            $display("timeout: no new_config_available pulse within %0d cycles", SETTLE_CYCLES);
        end
        for (k = 0; k < 4; k++) @(negedge clk);
    endtask

    task automatic compare_state();
        if (configuration !== exp_conf) begin
            report_mismatch("configuration", 64'(configuration), 64'(exp_conf));
        end
        if (rgb_enable !== exp_rgb) begin
            report_mismatch("rgb_enable", 64'(rgb_enable), 64'(exp_rgb));
        end
        if (pulse_cnt != exp_pulses) begin
            report_mismatch("new_config_available pulse count", 64'(pulse_cnt), 64'(exp_pulses));
        end
    endtask

    // send one frame, advance the model, then compare
    task automatic apply_frame(input logic [71:0] bytes, input int n, output logic [71:0] rx);
        logic [CONF_W+1:0] pred;
        pred = predict_frame(bytes, n, exp_conf, exp_rgb);
        spi_transfer(bytes, n, rx);
        exp_conf = pred[CONF_W-1:0];
        exp_rgb  = pred[CONF_W];
        if (pred[CONF_W+1]) begin
            exp_pulses++;
        end
        finish_frame(pred[CONF_W+1]);
        compare_state();
    endtask

    // priming hall edge, then a measured gap of n cycles, then readback over spi
    task automatic check_rotation(input int n);
        int               k;
        bit               seen;
        logic [ROT_W-1:0] exp_rot;
        logic [71:0]      rx;
        exp_rot = predict_rotation(n);
        @(negedge clk);
        hall = 1'b0;
        @(negedge clk);
        @(negedge clk);
        hall = 1'b1;
        for (k = 1; k <= n; k++) begin
            @(negedge clk);
            if (k == 2) hall = 1'b0;
            if (k == n) hall = 1'b1;
        end
        // latch lands 3 cycles after the pin edge
        seen = 1'b0;
        for (k = 1; k <= ROT_WAIT && !seen; k++) begin
            @(negedge clk);
            if (k >= 3 && rotation_data === exp_rot) begin
                seen = 1'b1;
            end
        end
        if (rotation_data !== exp_rot) begin
            report_mismatch("rotation_data", 64'(rotation_data), 64'(exp_rot));
        end
        apply_frame({OP_READ_ROT, 64'h0}, 3, rx);
        if (rx[63:48] !== exp_rot) begin
            report_mismatch("miso rotation reply", 64'(rx[63:48]), 64'(exp_rot));
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        seed         = 32'h4873;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        pulse_cnt    = 0;
        exp_pulses   = 0;
        exp_conf     = '0;
        exp_rgb      = 1'b0;
        hall         = 1'b0;
        som_clk      = 1'b0;
        som_cs       = 1'b1;
        som_mosi     = 1'b0;

        for (i = 0; i < RST_WAIT && rst_n !== 1'b1; i++) @(negedge clk);
        if (rst_n !== 1'b1) begin
            errors++;
            $display("timeout: reset was never released");
        end

        // reset values
        err0 = errors;
        compare_state();
        if (rotation_data !== '0) begin
            report_mismatch("rotation_data after reset", 64'(rotation_data), 64'h0);
        end
        end_test("reset", err0);

        // full write frame with random payload
        err0 = errors;
        rnd  = {$random(seed), $random(seed)};
        apply_frame({OP_WRITE_CONF, rnd[CONF_W-1:0], 16'h0}, 7, miso);
        end_test("config_write", err0);

        // only bit 0 of byte 1 matters
        err0 = errors;
        apply_frame({OP_RGB_EN, 8'h81, 56'h0}, 2, miso);
        apply_frame({OP_RGB_EN, 8'hfe, 56'h0}, 2, miso);
        end_test("rgb_enable", err0);

        // random spacing, then a gap past the counter range
        err0 = errors;
        for (i = 0; i < 3; i++) begin
            check_rotation(24 + ($unsigned($random(seed)) % 600));
        end
        check_rotation(65535 * ROT_DIV + 37);
        end_test("rotation", err0);

        // set a known level first so an unwanted change would show
        err0 = errors;
        apply_frame({OP_RGB_EN, 8'h01, 56'h0}, 2, miso);
        rnd = {$random(seed), $random(seed)};
        apply_frame({OP_WRITE_CONF, rnd}, 5, miso);
        rnd = {$random(seed), $random(seed)};
        apply_frame({OP_WRITE_CONF, rnd}, 9, miso);
        rnd = {$random(seed), $random(seed)};
        apply_frame({8'h5a, rnd}, 7, miso);
        end_test("rejected_frames", err0);

        $display("summary: %0d tests, %0d ok, %0d with errors, %0d errors in total",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/tb_clk_gen.sv ====
// testbench clock and reset source: 8 ns clock, reset low for the first 4 cycles
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    localparam real HALF_PERIOD = 4.0;
    localparam int  RST_CYCLES  = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release on a falling edge, away from the dut sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== spi_decoder/spi_decoder.sv ====
// spi frame decoder: applies write configuration and rgb enable commands from the host
`timescale 1ns/1ps

module spi_decoder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [pov_pkg::FRAME_W-1:0] frame_data,
    input  logic [pov_pkg::LEN_W-1:0]   frame_len,
    input  logic                        frame_valid,
    output logic [pov_pkg::CONF_W-1:0]  configuration,
    output logic                        new_config_available,
    output logic                        rgb_enable
);
    import pov_pkg::*;

    // frame seen both as bytes and as opcode plus payload
    spi_frame_u frame;

    // accepted commands of the current frame
    logic write_hit;
    logic rgb_hit;

    assign frame = frame_data;

    // command decode
    // read rotation needs no action here, its reply already went out on miso
    always_comb begin
        write_hit = 1'b0;
        rgb_hit   = 1'b0;
        if (frame_valid) begin
            case (frame.fields.opcode)
                OP_WRITE_CONF: begin
                    // full frame only, opcode plus 6 payload bytes
                    write_hit = (frame_len == LEN_W'(FRAME_BYTES));
                end
                OP_RGB_EN: begin
                    // opcode plus a single level byte
                    rgb_hit = (frame_len == LEN_W'(RGB_LEN));
                end
                default: begin
                    // unknown opcodes are dropped silently
                    write_hit = 1'b0;
                    rgb_hit   = 1'b0;
                end
            endcase
        end
    end

    // configuration register for the led driver
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            configuration <= '0;
        end else if (write_hit) begin
            configuration <= frame.fields.payload;
        end
    end

    // one cycle strobe alongside each configuration update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            new_config_available <= 1'b0;
        end else begin
            new_config_available <= write_hit;
        end
    end

    // rgb enable level, bit 0 of byte 1
    // held until the next valid set rgb enable frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb_enable <= 1'b0;
        end else if (rgb_hit) begin
            rgb_enable <= frame.bytes[1][0];
        end
    end

endmodule

// ==== spi_iff/spi_iff.sv ====
// spi mode-0 slave: syncs pins, collects up to seven frame bytes, shifts out rotation reply
`timescale 1ns/1ps

module spi_iff (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        spi_clk,
    input  logic                        spi_ss,
    input  logic                        spi_mosi,
    output logic                        spi_miso,
    input  logic [pov_pkg::ROT_W-1:0]   tx_data,
    output logic [pov_pkg::FRAME_W-1:0] frame_data,
    output logic [pov_pkg::LEN_W-1:0]   frame_len,
    output logic                        frame_valid
);
    import pov_pkg::*;

    // two sync stages plus one history stage for edge detection
    logic [2:0]                  sclk_q;
    logic [2:0]                  ss_q;
    logic [1:0]                  mosi_q;
    logic                        sclk_rise;
    logic                        sclk_fall;
    logic                        ss_rise;
    logic                        ss_fall;
    logic                        ss_active;
    // receive side
    logic [$clog2(BYTE_W)-1:0]   bit_cnt;
    logic [BYTE_W-2:0]           rx_byte;
    logic [BYTE_W-1:0]           rx_next;
    logic                        byte_done;
    logic [LEN_W-1:0]            byte_cnt;
    logic                        overflow;
    logic [FRAME_W-1:0]          frame_buf;
    // transmit side
    logic                        load_tx;
    logic [ROT_W-1:0]            tx_shift;
    logic [TXCNT_W-1:0]          tx_cnt;
    logic                        miso_q;

    // chip select idles high, so its sync chain resets to ones
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_q <= '0;
            ss_q   <= '1;
            mosi_q <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], spi_clk};
            ss_q   <= {ss_q[1:0], spi_ss};
            mosi_q <= {mosi_q[0], spi_mosi};
        end
    end

    assign sclk_rise = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall = ~sclk_q[1] & sclk_q[2];
    assign ss_rise   = ss_q[1] & ~ss_q[2];
    assign ss_fall   = ~ss_q[1] & ss_q[2];
    assign ss_active = ~ss_q[1];

    // full byte including the bit sampled on this edge, msb first
    assign rx_next   = {rx_byte, mosi_q[1]};
    assign byte_done = sclk_rise && (bit_cnt == '1);
    // reply is loaded once, when byte 0 completes
    assign load_tx   = ss_active && byte_done && (byte_cnt == '0) && !overflow;

    // bit and byte counters, restarted at every cs fall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            overflow <= 1'b0;
        end else if (ss_fall) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            overflow <= 1'b0;
        end else if (ss_active && sclk_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (byte_done) begin
                // an eighth byte marks the frame as too long
                if (byte_cnt == LEN_W'(FRAME_BYTES)) begin
                    overflow <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // byte shifter and frame store
    always_ff @(posedge clk) begin
        if (ss_fall) begin
            // unreceived bytes must read back as zero
            frame_buf <= '0;
        end else if (ss_active && sclk_rise) begin
            rx_byte <= rx_next[BYTE_W-2:0];
            if (byte_done && byte_cnt != LEN_W'(FRAME_BYTES)) begin
                frame_buf[(FRAME_BYTES - 1 - int'(byte_cnt)) * BYTE_W +: BYTE_W] <= rx_next;
            end
        end
    end

    // end of frame strobe, third clk edge after the cs pin rises
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= ss_rise;
        end
    end

    assign frame_data = frame_buf;
    assign frame_len  = overflow ? '0 : byte_cnt;

    // reply control, miso moves on falling sclk so the master samples it on the rise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_cnt <= '0;
            miso_q <= 1'b0;
        end else if (!ss_active) begin
            tx_cnt <= '0;
            miso_q <= 1'b0;
        end else if (load_tx) begin
            tx_cnt <= TXCNT_W'(ROT_W);
        end else if (sclk_fall) begin
            if (tx_cnt != '0) begin
                miso_q <= tx_shift[ROT_W-1];
                tx_cnt <= tx_cnt - 1'b1;
            end else begin
                // drained after byte 2
                miso_q <= 1'b0;
            end
        end
    end

    // reply data shifter
    always_ff @(posedge clk) begin
        if (load_tx) begin
            tx_shift <= tx_data;
        end else if (ss_active && sclk_fall && tx_cnt != '0) begin
            tx_shift <= {tx_shift[ROT_W-2:0], 1'b0};
        end
    end

    // the raw pin keeps miso low during the cs sync delay
    assign spi_miso = miso_q & ~spi_ss;

endmodule
